// File: mldsa_params_pkg.sv
// ML-DSA algorithm constants and the stored coefficient type
package mldsa_params_pkg;

  // Width of a full value modulo Q
  localparam int MLDSA_Q_WIDTH = 24;

  // The ML-DSA prime modulus, 2^23 - 2^13 + 1
  localparam logic [MLDSA_Q_WIDTH-1:0] MLDSA_Q = 24'd8380417;

  // Number of coefficients in one polynomial
  localparam int MLDSA_N = 256;

  // Number of nonzero coefficients in the challenge polynomial
  localparam int MLDSA_TAU = 60;

  // A stored coefficient drops the top bit, since Q-1 still fits in 23 bits
  // and the challenge only ever holds 0, 1 or Q-1
  typedef logic [MLDSA_Q_WIDTH-2:0] mldsa_coeff_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# Build the SampleInBall testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module sib_tb -f src.f

out=$(./obj_dir/Vsib_tb 2>&1) || true
printf '%s\n' "$out"

# The run passes only if the testbench printed its pass line
printf '%s\n' "$out" | grep -q "^Simulation finished: PASS$"

// File: sample_in_ball_shuffler.sv
// SampleInBall shuffler: moves coefficient j to i and writes the signed one at j
module sample_in_ball_shuffler (
  input  logic                                      clk,
  input  logic                                      rst_b,
  input  logic                                      zeroize_i,
  input  logic                                      valid_i,
  output logic                                      hold_o,
  input  logic [sib_mem_pkg::SIB_SAMPLE_W-1:0]      indexi_i,
  input  logic [sib_mem_pkg::SIB_SAMPLE_W-1:0]      indexj_i,
  input  logic                                      sign_i,
  output logic [1:0]                                cs_o,
  output logic [1:0]                                we_o,
  output logic [1:0][sib_mem_pkg::SIB_ADDR_W-1:0]   addr_o,
  output sib_mem_pkg::sib_word_t [1:0]              wrdata_o,
  input  sib_mem_pkg::sib_word_t [1:0]              rddata_i
);
  import mldsa_params_pkg::*;
  import sib_mem_pkg::*;

  logic                                     read_valid_q;
  logic                                     addr_match;
  logic [SIB_ADDR_W-1:0]                    word_i;
  logic [SIB_ADDR_W-1:0]                    word_j;
  logic [SIB_SAMPLE_W-SIB_ADDR_W-1:0]       lane_i;
  logic [SIB_SAMPLE_W-SIB_ADDR_W-1:0]       lane_j;
  mldsa_coeff_t                             signed_one;
  mldsa_coeff_t                             old_j;

  // Split both indices into word address and lane within the word
  assign word_i = indexi_i[SIB_SAMPLE_W-1 -: SIB_ADDR_W];
  assign word_j = indexj_i[SIB_SAMPLE_W-1 -: SIB_ADDR_W];
  assign lane_i = indexi_i[SIB_SAMPLE_W-SIB_ADDR_W-1:0];
  assign lane_j = indexj_i[SIB_SAMPLE_W-SIB_ADDR_W-1:0];

  assign addr_match = (word_i == word_j);

  // The first cycle of a request is the read, control must hold the
  // request for one more cycle while this is high
  assign hold_o = valid_i & ~read_valid_q;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      read_valid_q <= 1'b0;
    end else if (zeroize_i) begin
      read_valid_q <= 1'b0;
    end else begin
      // Marks the write phase, which always follows the read by one cycle
      read_valid_q <= hold_o;
    end
  end

  // Port 0 serves j's word and port 1 serves i's word in both phases
  assign addr_o[0] = word_j;
  assign addr_o[1] = word_i;

  assign cs_o = {2{valid_i}};

  // Port 1 always writes i's word, port 0 stands down when both
  // indices share a word so only one write reaches that word
  assign we_o[1] = valid_i & read_valid_q;
  assign we_o[0] = valid_i & read_valid_q & ~addr_match;

  // Sign bit 1 selects -1 mod Q
  assign signed_one = sign_i ? mldsa_coeff_t'(MLDSA_Q - 1'b1) : mldsa_coeff_t'(1);

  // The coefficient that moves from j to i, taken from the word read at j
  assign old_j = rddata_i[0][lane_j];

  // Port 0 write word, j's lane replaced by the signed one
  always_comb begin
    wrdata_o[0]         = rddata_i[0];
    wrdata_o[0][lane_j] = signed_one;
  end

  // Port 1 write word, i's lane takes the old j coefficient. With a
  // shared word this port also carries the signed one, applied last so
  // that j equal to i ends with the signed value at i
  always_comb begin
    wrdata_o[1]         = rddata_i[1];
    wrdata_o[1][lane_i] = old_j;
    if (addr_match) begin
      wrdata_o[1][lane_j] = signed_one;
    end
  end

endmodule

// File: sample_in_ball_top.sv
// SampleInBall top level: control, sign register, shuffler and coefficient memory
module sample_in_ball_top (
  input  logic                                 clk,
  input  logic                                 rst_b,
  input  logic                                 zeroize_i,
  input  logic                                 start_i,
  input  logic                                 byte_valid_i,
  input  logic [sib_mem_pkg::SIB_SAMPLE_W-1:0] byte_i,
  output logic                                 busy_o,
  output logic                                 done_o,
  input  logic [sib_mem_pkg::SIB_SAMPLE_W-1:0] rd_addr_i,
  output mldsa_params_pkg::mldsa_coeff_t       rd_coeff_o
);
  import mldsa_params_pkg::*;
  import sib_mem_pkg::*;

  // Control outputs
  logic                    mem_clear;
  logic                    sign_load;
  logic [SIB_SAMPLE_W-1:0] sign_byte;
  logic                    sign_shift;
  logic                    sign;
  logic                    shuf_valid;
  logic                    shuf_hold;
  logic [SIB_SAMPLE_W-1:0] shuf_index_i;
  logic [SIB_SAMPLE_W-1:0] shuf_index_j;

  // Shuffler to memory, port 0 for j and port 1 for i
  logic [1:0]                 mem_cs;
  logic [1:0]                 mem_we;
  logic [1:0][SIB_ADDR_W-1:0] mem_addr;
  sib_word_t [1:0]            mem_wrdata;
  sib_word_t [1:0]            mem_rddata;

  sib_ctrl i_ctrl (
    .clk            (clk),
    .rst_b          (rst_b),
    .zeroize_i      (zeroize_i),
    .start_i        (start_i),
    .byte_valid_i   (byte_valid_i),
    .byte_i         (byte_i),
    .busy_o         (busy_o),
    .done_o         (done_o),
    .mem_clear_o    (mem_clear),
    .sign_load_o    (sign_load),
    .sign_byte_o    (sign_byte),
    .sign_shift_o   (sign_shift),
    .shuf_valid_o   (shuf_valid),
    .shuf_index_i_o (shuf_index_i),
    .shuf_index_j_o (shuf_index_j),
    .shuf_hold_i    (shuf_hold)
  );

  // The memory clear strobe also restarts the sign byte count on start
  sib_sign_reg i_sign_reg (
    .clk         (clk),
    .rst_b       (rst_b),
    .zeroize_i   (mem_clear),
    .load_i      (sign_load),
    .load_byte_i (sign_byte),
    .shift_i     (sign_shift),
    .sign_o      (sign)
  );

  sample_in_ball_shuffler i_shuffler (
    .clk       (clk),
    .rst_b     (rst_b),
    .zeroize_i (zeroize_i),
    .valid_i   (shuf_valid),
    .hold_o    (shuf_hold),
    .indexi_i  (shuf_index_i),
    .indexj_i  (shuf_index_j),
    .sign_i    (sign),
    .cs_o      (mem_cs),
    .we_o      (mem_we),
    .addr_o    (mem_addr),
    .wrdata_o  (mem_wrdata),
    .rddata_i  (mem_rddata)
  );

  sib_coeff_mem i_mem (
    .clk        (clk),
    .rst_b      (rst_b),
    .clear_i    (mem_clear),
    .cs_i       (mem_cs),
    .we_i       (mem_we),
    .addr_i     (mem_addr),
    .wrdata_i   (mem_wrdata),
    .rddata_o   (mem_rddata),
    .rd_addr_i  (rd_addr_i),
    .rd_coeff_o (rd_coeff_o)
  );

endmodule

// File: sib_checker.sv
// Concurrent assertions on the SampleInBall top level, attached by bind
module sib_checker (
  input logic                           clk,
  input logic                           rst_b,
  input logic                           zeroize_i,
  input logic                           start_i,
  input logic                           byte_valid_i,
  input logic                           busy_i,
  input logic                           done_i,
  input mldsa_params_pkg::mldsa_coeff_t rd_coeff_i
);
  timeunit 1ns;
  timeprecision 100ps;
  import mldsa_params_pkg::*;

  localparam mldsa_coeff_t COEFF_ONE       = mldsa_coeff_t'(1);
  localparam mldsa_coeff_t COEFF_MINUS_ONE = mldsa_coeff_t'(MLDSA_Q - 1);

  // Failed assertions, read by the testbench for its final count
  int unsigned fail_cnt = 0;
  logic        seen_start_q;
  logic        busy_q;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      seen_start_q <= 1'b0;
      busy_q       <= 1'b0;
    end else begin
      if (start_i) begin
        seen_start_q <= 1'b1;
      end
      busy_q <= busy_i;
    end
  end

  // Nothing runs between reset and the first start
  idle_before_start: assert property (@(posedge clk) disable iff (!rst_b)
    !seen_start_q |-> (!busy_i && !done_i))
    else begin
      fail_cnt++;
      $error("busy_o or done_o active before the first start");
    end

  // Done is a single-cycle pulse
  done_single_cycle: assert property (@(posedge clk) disable iff (!rst_b)
    done_i |=> !done_i)
    else begin
      fail_cnt++;
      $error("done_o held high for more than one cycle");
    end

  // Busy falls in the very cycle that done pulses
  done_ends_busy: assert property (@(posedge clk) disable iff (!rst_b)
    done_i |-> (busy_q && !busy_i))
    else begin
      fail_cnt++;
      $error("busy_o did not fall together with done_o");
    end

  zeroize_stops_run: assert property (@(posedge clk) disable iff (!rst_b)
    zeroize_i |=> !busy_i)
    else begin
      fail_cnt++;
      $error("busy_o still high after zeroize_i");
    end

  // Upstream rule, two byte strobes never come back to back
  byte_spacing: assert property (@(posedge clk) disable iff (!rst_b)
    byte_valid_i |=> !byte_valid_i)
    else begin
      fail_cnt++;
      $error("byte_valid_i high on two consecutive cycles");
    end

  // A challenge coefficient is always 0, 1 or Q-1
  coeff_range: assert property (@(posedge clk) disable iff (!rst_b)
    !busy_i |-> ((rd_coeff_i == '0) || (rd_coeff_i == COEFF_ONE) ||
                 (rd_coeff_i == COEFF_MINUS_ONE)))
    else begin
      fail_cnt++;
      $error("rd_coeff_o outside of 0, 1 and Q-1");
    end

endmodule

bind sample_in_ball_top sib_checker i_checker (
  .clk          (clk),
  .rst_b        (rst_b),
  .zeroize_i    (zeroize_i),
  .start_i      (start_i),
  .byte_valid_i (byte_valid_i),
  .busy_i       (busy_o),
  .done_i       (done_o),
  .rd_coeff_i   (rd_coeff_o)
);

// File: sib_coeff_mem.sv
// Two-port packed coefficient memory with bulk clear and a single-lane readout
module sib_coeff_mem (
  input  logic                                    clk,
  input  logic                                    rst_b,
  input  logic                                    clear_i,
  input  logic [1:0]                              cs_i,
  input  logic [1:0]                              we_i,
  input  logic [1:0][sib_mem_pkg::SIB_ADDR_W-1:0] addr_i,
  input  sib_mem_pkg::sib_word_t [1:0]            wrdata_i,
  output sib_mem_pkg::sib_word_t [1:0]            rddata_o,
  input  logic [sib_mem_pkg::SIB_SAMPLE_W-1:0]    rd_addr_i,
  output mldsa_params_pkg::mldsa_coeff_t          rd_coeff_o
);
  import mldsa_params_pkg::*;
  import sib_mem_pkg::*;

  sib_word_t mem_q [2**SIB_ADDR_W];

  // Flop array, cleared in a single cycle at the start of every run
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      mem_q <= '{default: '0};
    end else if (clear_i) begin
      mem_q <= '{default: '0};
    end else begin
      // Port 1 is written last, so it wins when both ports hit one word
      for (int p = 0; p < 2; p++) begin
        if (cs_i[p] && we_i[p]) begin
          mem_q[addr_i[p]] <= wrdata_i[p];
        end
      end
    end
  end

  // Synchronous reads, data for an address shows up one cycle later
  always_ff @(posedge clk) begin
    for (int p = 0; p < 2; p++) begin
      if (cs_i[p]) begin
        rddata_o[p] <= mem_q[addr_i[p]];
      end
    end
  end

  // Readout picks one lane of the addressed word and registers it
  always_ff @(posedge clk) begin
    rd_coeff_o <= mem_q[rd_addr_i[SIB_SAMPLE_W-1 -: SIB_ADDR_W]]
                       [rd_addr_i[SIB_SAMPLE_W-SIB_ADDR_W-1:0]];
  end

endmodule

// File: sib_ctrl.sv
// SampleInBall control FSM: clear, sign loading, rejection sampling and shuffle
module sib_ctrl (
  input  logic                                 clk,
  input  logic                                 rst_b,
  input  logic                                 zeroize_i,
  input  logic                                 start_i,
  input  logic                                 byte_valid_i,
  input  logic [sib_mem_pkg::SIB_SAMPLE_W-1:0] byte_i,
  output logic                                 busy_o,
  output logic                                 done_o,
  output logic                                 mem_clear_o,
  output logic                                 sign_load_o,
  output logic [sib_mem_pkg::SIB_SAMPLE_W-1:0] sign_byte_o,
  output logic                                 sign_shift_o,
  output logic                                 shuf_valid_o,
  output logic [sib_mem_pkg::SIB_SAMPLE_W-1:0] shuf_index_i_o,
  output logic [sib_mem_pkg::SIB_SAMPLE_W-1:0] shuf_index_j_o,
  input  logic                                 shuf_hold_i
);
  import mldsa_params_pkg::*;
  import sib_mem_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    SIGNS,
    SAMPLE
  } sib_state_e;

  sib_state_e                        state_q;
  logic [$clog2(SIB_SIGN_BYTES)-1:0] sign_cnt_q;
  logic [SIB_SAMPLE_W-1:0]           index_i_q;
  logic [SIB_SAMPLE_W-1:0]           index_j_q;
  logic                              pending_q;
  logic                              done_q;
  logic                              run_kill;
  logic                              sample_hit;
  logic                              write_commit;
  logic                              last_pos;

  // Start or zeroize abandons whatever is in flight
  assign run_kill = start_i | zeroize_i;

  // The memory clears at the edge that sees start or zeroize
  assign mem_clear_o = run_kill;

  // Sign bytes go straight to the sign register
  assign sign_load_o = (state_q == SIGNS) & byte_valid_i & ~run_kill;
  assign sign_byte_o = byte_i;

  // Rejection test, a candidate above the current position is dropped.
  // Nothing is accepted during the write cycle of the previous sample
  assign sample_hit = (state_q == SAMPLE) & byte_valid_i & ~pending_q &
                      (byte_i <= index_i_q) & ~run_kill;

  // Second cycle of an accepted sample, the shuffler writes now
  assign write_commit = pending_q & ~run_kill;

  assign last_pos = (index_i_q == SIB_SAMPLE_W'(MLDSA_N - 1));

  // The byte is used directly in the read cycle and the held copy in the
  // write cycle, so the indices stay stable across both
  assign shuf_valid_o   = sample_hit | write_commit;
  assign shuf_index_i_o = index_i_q;
  assign shuf_index_j_o = pending_q ? index_j_q : byte_i;

  // One sign bit is consumed per committed sample
  assign sign_shift_o = write_commit;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state_q    <= IDLE;
      sign_cnt_q <= '0;
      index_i_q  <= '0;
      pending_q  <= 1'b0;
      done_q     <= 1'b0;
    end else if (zeroize_i) begin
      state_q    <= IDLE;
      sign_cnt_q <= '0;
      index_i_q  <= '0;
      pending_q  <= 1'b0;
      done_q     <= 1'b0;
    end else if (start_i) begin
      // A start while busy simply begins a fresh run
      state_q    <= SIGNS;
      sign_cnt_q <= '0;
      index_i_q  <= SIB_I_START;
      pending_q  <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      done_q <= 1'b0;
      unique case (state_q)
        SIGNS: begin
          if (byte_valid_i) begin
            sign_cnt_q <= sign_cnt_q + 1'b1;
            if (sign_cnt_q == SIB_SIGN_BYTES - 1) begin
              state_q <= SAMPLE;
            end
          end
        end
        SAMPLE: begin
          if (write_commit) begin
            pending_q <= 1'b0;
            if (last_pos) begin
              // Position 255 is written, done pulses while busy falls
              state_q <= IDLE;
              done_q  <= 1'b1;
            end else begin
              index_i_q <= index_i_q + 1'b1;
            end
          end else if (sample_hit && shuf_hold_i) begin
            // Read phase accepted, the write follows next cycle
            pending_q <= 1'b1;
          end
        end
        default: begin
          // Bytes are ignored while idle
        end
      endcase
    end
  end

  // Capture j for the write cycle
  always_ff @(posedge clk) begin
    if (sample_hit) begin
      index_j_q <= byte_i;
    end
  end

  assign busy_o = (state_q != IDLE);
  assign done_o = done_q;

endmodule

// File: sib_mem_pkg.sv
// Packed coefficient memory layout and sample index widths for SampleInBall
package sib_mem_pkg;

  // One index byte from the XOF stream addresses one of 256 coefficients
  localparam int SIB_SAMPLE_W = 8;

  // Four coefficients share one memory word
  localparam int SIB_WORD_COEFFS = 4;

  // Word address, the upper bits of a coefficient index
  localparam int SIB_ADDR_W = 6;

  // The first eight bytes of the stream carry the sign bits
  localparam int SIB_SIGN_BYTES = 8;
  localparam int SIB_SIGN_W = 64;

  // Position i starts here and walks up to N-1
  localparam logic [SIB_SAMPLE_W-1:0] SIB_I_START =
    SIB_SAMPLE_W'(mldsa_params_pkg::MLDSA_N - mldsa_params_pkg::MLDSA_TAU);

  // One memory word, lane 0 holds the coefficient with index bits [1:0] = 0
  typedef mldsa_params_pkg::mldsa_coeff_t [SIB_WORD_COEFFS-1:0] sib_word_t;

endpackage

// File: sib_sign_reg.sv
// Sign-bit register, filled one byte at a time and shifted per accepted sample
module sib_sign_reg (
  input  logic                                 clk,
  input  logic                                 rst_b,
  input  logic                                 zeroize_i,
  input  logic                                 load_i,
  input  logic [sib_mem_pkg::SIB_SAMPLE_W-1:0] load_byte_i,
  input  logic                                 shift_i,
  output logic                                 sign_o
);
  import sib_mem_pkg::*;

  logic [SIB_SIGN_W-1:0]              sign_q;
  logic [$clog2(SIB_SIGN_BYTES)-1:0] byte_cnt_q;

  // Byte k of the stream lands in bits 8k+7 down to 8k, so the first
  // byte's bit 0 is the first sign to be used
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      sign_q     <= '0;
      byte_cnt_q <= '0;
    end else if (zeroize_i) begin
      sign_q     <= '0;
      byte_cnt_q <= '0;
    end else if (load_i) begin
      sign_q[byte_cnt_q*SIB_SAMPLE_W +: SIB_SAMPLE_W] <= load_byte_i;
      // The count wraps back to zero after the eighth byte
      byte_cnt_q <= byte_cnt_q + 1'b1;
    end else if (shift_i) begin
      // Consume the current sign, the next one moves into bit 0
      sign_q <= sign_q >> 1;
    end
  end

  // The current sign feeds the shuffler's write of 1 or Q-1
  assign sign_o = sign_q[0];

endmodule

// File: sib_tb.sv
// SampleInBall testbench that checks random and directed runs against a reference model
module sib_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import mldsa_params_pkg::*;
  import sib_mem_pkg::*;

  localparam int unsigned  RAND_SEED     = 32'h1e90_8fc2;
  localparam int           RESET_TIMEOUT = 20;
  localparam int           DONE_TIMEOUT  = 40;
  localparam int           MAX_BYTES     = 20000;
  localparam mldsa_coeff_t COEFF_ONE       = mldsa_coeff_t'(1);
  localparam mldsa_coeff_t COEFF_MINUS_ONE = mldsa_coeff_t'(MLDSA_Q - 1);

  logic                    clk;
  logic                    rst_b;
  logic                    zeroize;
  logic                    start;
  logic                    byte_valid;
  logic [SIB_SAMPLE_W-1:0] byte_data;
  logic [SIB_SAMPLE_W-1:0] rd_addr;
  logic                    busy;
  logic                    done;
  mldsa_coeff_t            rd_coeff;

  // Reference state that is built from the same bytes the DUT sees
  mldsa_coeff_t          model_c [MLDSA_N];
  logic [SIB_SIGN_W-1:0] model_sign;
  int                    model_i;

  int          mismatch_cnt;
  int          other_cnt;
  int          timeout_cnt;

  sib_tb_clk i_clk (
    .clk   (clk),
    .rst_b (rst_b)
  );

  sample_in_ball_top i_dut (
    .clk          (clk),
    .rst_b        (rst_b),
    .zeroize_i    (zeroize),
    .start_i      (start),
    .byte_valid_i (byte_valid),
    .byte_i       (byte_data),
    .busy_o       (busy),
    .done_o       (done),
    .rd_addr_i    (rd_addr),
    .rd_coeff_o   (rd_coeff)
  );

  task automatic report_and_finish();
    int assert_cnt;
    assert_cnt = int'(i_dut.i_checker.fail_cnt);
    $display("Errors: %0d mismatches, %0d other, %0d timeouts, %0d assertion failures",
             mismatch_cnt, other_cnt, timeout_cnt, assert_cnt);
    if (mismatch_cnt + other_cnt + timeout_cnt + assert_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  endtask

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, expected, actual);
      mismatch_cnt++;
    end
  endtask

  // In the standard SampleInBall swap c[i] takes c[j] and c[j] takes the signed one
  function automatic void model_accept(input logic [SIB_SAMPLE_W-1:0] b);
    if (model_i < MLDSA_N && int'(b) <= model_i) begin
      model_c[model_i] = model_c[b];
      model_c[b]       = model_sign[0] ? COEFF_MINUS_ONE : COEFF_ONE;
      model_sign       = model_sign >> 1;
      model_i++;
    end
  endfunction

  // Drives one strobe and then one to three idle cycles unless the caller watches for done
  task automatic send_byte(input logic [SIB_SAMPLE_W-1:0] b, input bit last_byte);
    int gap;
    byte_valid = 1'b1;
    byte_data  = b;
    @(negedge clk);
    byte_valid = 1'b0;
    if (!last_byte) begin
      gap = $urandom_range(2, 0);
      repeat (1 + gap) @(negedge clk);
    end
  endtask

  task automatic start_run();
    logic [SIB_SAMPLE_W-1:0] b;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    check_value("busy_o", 1, int'(busy));
    model_c    = '{default: '0};
    model_i    = MLDSA_N - MLDSA_TAU;
    model_sign = '0;
    // Sign byte k supplies sign bits 8k up to 8k+7
    for (int k = 0; k < SIB_SIGN_BYTES; k++) begin
      b = SIB_SAMPLE_W'($urandom_range(255, 0));
      model_sign[k*SIB_SAMPLE_W +: SIB_SAMPLE_W] = b;
      send_byte(b, 1'b0);
    end
  endtask

  // Feeds sample bytes until the model has filled position N-1
  task automatic run_samples(input bit directed);
    logic [SIB_SAMPLE_W-1:0] b;
    logic [SIB_SAMPLE_W-1:0] directed_q [$];
    int                      sent;
    bit                      last_byte;
    sent = 0;
    directed_q = {};
    if (directed) begin
      // The queue gives j equal to i, j in i's word, a rejection, j equal to i again
      // and a far j
      directed_q.push_back(SIB_SAMPLE_W'(model_i));
      directed_q.push_back(SIB_SAMPLE_W'(model_i));
      directed_q.push_back(SIB_SAMPLE_W'(MLDSA_N - 6));
      directed_q.push_back(SIB_SAMPLE_W'(model_i + 2));
      directed_q.push_back(SIB_SAMPLE_W'(12));
    end
    while (model_i < MLDSA_N && sent < MAX_BYTES) begin
      if (directed_q.size() > 0) begin
        b = directed_q.pop_front();
      end else if (model_i < MLDSA_N - 1 && $urandom_range(3, 0) == 0) begin
        // Force a rejection with a candidate above the current position
        b = SIB_SAMPLE_W'($urandom_range(MLDSA_N - 1, model_i + 1));
      end else begin
        b = SIB_SAMPLE_W'($urandom_range(255, 0));
      end
      last_byte = (model_i == MLDSA_N - 1) && (int'(b) <= model_i);
      send_byte(b, last_byte);
      model_accept(b);
      sent++;
    end
    if (model_i < MLDSA_N) begin
      $display("Timeout: run not complete after %0d sample bytes", MAX_BYTES);
      timeout_cnt++;
      report_and_finish();
    end
  endtask

  task automatic wait_done();
    bit seen;
    seen = 1'b0;
    for (int n = 0; n < DONE_TIMEOUT && !seen; n++) begin
      @(negedge clk);
      seen = done;
    end
    if (!seen) begin
      $display("Timeout: done_o did not pulse after the last accepted byte");
      timeout_cnt++;
      report_and_finish();
    end
  endtask

  task automatic read_and_compare(input string tag, input int exp_nonzero);
    int nonzero;
    nonzero = 0;
    for (int k = 0; k < MLDSA_N; k++) begin
      rd_addr = SIB_SAMPLE_W'(k);
      @(negedge clk);
      if (rd_coeff !== model_c[k]) begin
        $display("[FAIL] %0t rd_coeff_o at coefficient %0d expected %0d actual %0d",
                 $time, k, model_c[k], rd_coeff);
        mismatch_cnt++;
      end
      if (rd_coeff != '0) begin
        nonzero++;
      end
    end
    if (nonzero != exp_nonzero) begin
      $display("Readout after %s holds %0d nonzero coefficients instead of %0d",
               tag, nonzero, exp_nonzero);
      other_cnt++;
    end
  endtask

  initial begin
    // Seed the generator once so that every run draws the same bytes
    void'($urandom(RAND_SEED));
    zeroize      = 1'b0;
    start        = 1'b0;
    byte_valid   = 1'b0;
    byte_data    = '0;
    rd_addr      = '0;
    mismatch_cnt = 0;
    other_cnt    = 0;
    timeout_cnt  = 0;

    // Reset changes on a falling edge, so it is sampled on the rising edge
    for (int n = 0; n < RESET_TIMEOUT && rst_b !== 1'b1; n++) begin
      @(posedge clk);
    end
    if (rst_b !== 1'b1) begin
      $display("Timeout: reset was never released");
      timeout_cnt++;
      report_and_finish();
    end
    repeat (3) @(negedge clk);
    check_value("busy_o", 0, int'(busy));
    check_value("done_o", 0, int'(done));

    // A random run is followed by a stray byte after done that must change nothing
    start_run();
    run_samples(1'b0);
    wait_done();
    send_byte(SIB_SAMPLE_W'($urandom_range(255, 0)), 1'b0);
    read_and_compare("random run", MLDSA_TAU);

    // A second start over the finished polynomial begins with directed indices
    start_run();
    run_samples(1'b1);
    wait_done();
    read_and_compare("directed run", MLDSA_TAU);

    // Zeroize part way through the sampling
    start_run();
    for (int k = 0; k < 20; k++) begin
      send_byte(SIB_SAMPLE_W'($urandom_range(255, 0)), 1'b0);
    end
    zeroize = 1'b1;
    @(negedge clk);
    zeroize = 1'b0;
    check_value("busy_o", 0, int'(busy));
    model_c = '{default: '0};
    read_and_compare("zeroize", 0);

    start_run();
    run_samples(1'b0);
    wait_done();
    read_and_compare("run after zeroize", MLDSA_TAU);

    report_and_finish();
  end

endmodule

// File: sib_tb_clk.sv
// Testbench clock and reset source, 40 ns clock and a four-cycle active-low reset
module sib_tb_clk (
  output logic clk,
  output logic rst_b
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam time HALF_PERIOD = 20ns;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // Reset spans four rising edges and is released on a falling edge
  initial begin
    rst_b = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_b = 1'b1;
  end

endmodule

// File: src.f
mldsa_params_pkg.sv
sib_mem_pkg.sv
sib_sign_reg.sv
sample_in_ball_shuffler.sv
sib_coeff_mem.sv
sib_ctrl.sv
sample_in_ball_top.sv
sib_checker.sv
sib_tb_clk.sv
sib_tb.sv
